// File: design/rv_pkg.sv
package rv_pkg;

  // ====================
  // word types
  // ====================

  typedef logic [31:0] xlen_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_addr_t;

  // ====================
  // opcodes
  // ====================

  // register-register, register-immediate and LUI only
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  // addi x0, x0, 0
  localparam inst_t NOP_INST = 32'h0000_0013;

  // ====================
  // alu operations
  // ====================

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    // result is operand b, used by lui
    ALU_PASS_B
  } alu_op_e;

  // ====================
  // stage records
  // ====================

  // decode to execute
  typedef struct packed {
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    xlen_t     rs1_data;
    xlen_t     rs2_data;
    xlen_t     imm;
    alu_op_e   alu_op;
    logic      use_imm;
    logic      reg_write;
  } id_ex_t;

  // result record for ex/mem and mem/wb
  typedef struct packed {
    reg_addr_t rd;
    xlen_t     data;
    logic      reg_write;
  } wb_req_t;

  // empty records, nothing gets written
  localparam id_ex_t ID_EX_NOP = '{
    rs1:       '0,
    rs2:       '0,
    rd:        '0,
    rs1_data:  '0,
    rs2_data:  '0,
    imm:       '0,
    alu_op:    ALU_ADD,
    use_imm:   1'b1,
    reg_write: 1'b0
  };

  localparam wb_req_t WB_NOP = '{rd: '0, data: '0, reg_write: 1'b0};

endpackage

// File: design/alu.sv
`timescale 1ns/1ps

module alu (
  input  rv_pkg::alu_op_e op_i,
  input  rv_pkg::xlen_t   a_i,
  input  rv_pkg::xlen_t   b_i,
  output rv_pkg::xlen_t   result_o
);

  import rv_pkg::*;

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  // only the low five bits shift
  assign shamt = b_i[4:0];

  assign lt_signed   = $signed(a_i) < $signed(b_i);
  assign lt_unsigned = a_i < b_i;

  always_comb begin
    case (op_i)
      ALU_ADD:    result_o = a_i + b_i;
      ALU_SUB:    result_o = a_i - b_i;
      ALU_SLL:    result_o = a_i << shamt;
      ALU_SLT:    result_o = {31'b0, lt_signed};
      ALU_SLTU:   result_o = {31'b0, lt_unsigned};
      ALU_XOR:    result_o = a_i ^ b_i;
      ALU_SRL:    result_o = a_i >> shamt;
      // arithmetic shift keeps the sign bit
      ALU_SRA:    result_o = $unsigned($signed(a_i) >>> shamt);
      ALU_OR:     result_o = a_i | b_i;
      ALU_AND:    result_o = a_i & b_i;
      ALU_PASS_B: result_o = b_i;
      default:    result_o = '0;
    endcase
  end

endmodule

// File: design/reg_file.sv
`timescale 1ns/1ps

module reg_file (
  input  logic              clk,
  input  logic              rst_i,
  input  logic              we_i,
  input  rv_pkg::reg_addr_t waddr_i,
  input  rv_pkg::xlen_t     wdata_i,
  input  rv_pkg::reg_addr_t raddr1_i,
  input  rv_pkg::reg_addr_t raddr2_i,
  output rv_pkg::xlen_t     rdata1_o,
  output rv_pkg::xlen_t     rdata2_o
);

  import rv_pkg::*;

  // x0 has no storage
  xlen_t regs [31:1];
  logic  wr_en;

  assign wr_en = we_i && (waddr_i != '0);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // same-cycle write shows up on the read
  function automatic xlen_t read_port(input reg_addr_t raddr);
    if (raddr == '0) begin
      return '0;
    end else if (wr_en && waddr_i == raddr) begin
      return wdata_i;
    end
    return regs[raddr];
  endfunction

  always_comb begin
    rdata1_o = read_port(raddr1_i);
    rdata2_o = read_port(raddr2_i);
  end

endmodule

// File: design/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
  input  logic            clk,
  input  logic            rst_i,
  input  logic            inst_valid_i,
  input  rv_pkg::inst_t   inst_i,
  input  rv_pkg::wb_req_t wb_i,
  output rv_pkg::id_ex_t  id_ex_o
);

  import rv_pkg::*;

  inst_t      inst_q;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_addr_t  rs1;
  reg_addr_t  rs2;
  reg_addr_t  rd;
  xlen_t      rs1_data;
  xlen_t      rs2_data;
  xlen_t      imm_i;
  xlen_t      imm_shamt;
  xlen_t      imm_u;
  id_ex_t     id_ex_d;
  id_ex_t     id_ex_q;

  // ====================
  // input register
  // ====================

  // bubble cycles load a nop
  always_ff @(posedge clk) begin
    if (rst_i || !inst_valid_i) begin
      inst_q <= NOP_INST;
    end else begin
      inst_q <= inst_i;
    end
  end

  // instruction fields
  assign opcode = inst_q[6:0];
  assign rd     = inst_q[11:7];
  assign funct3 = inst_q[14:12];
  assign rs1    = inst_q[19:15];
  assign rs2    = inst_q[24:20];
  assign funct7 = inst_q[31:25];

  // immediates
  assign imm_i     = {{20{inst_q[31]}}, inst_q[31:20]};
  assign imm_shamt = {27'b0, inst_q[24:20]};
  assign imm_u     = {inst_q[31:12], 12'b0};

  // write-through bypass lives in the register file
  reg_file reg_file_inst (
    .clk      (clk),
    .rst_i    (rst_i),
    .we_i     (wb_i.reg_write),
    .waddr_i  (wb_i.rd),
    .wdata_i  (wb_i.data),
    .raddr1_i (rs1),
    .raddr2_i (rs2),
    .rdata1_o (rs1_data),
    .rdata2_o (rs2_data)
  );

  // ====================
  // control decode
  // ====================

  always_comb begin
    id_ex_d          = ID_EX_NOP;
    id_ex_d.rs1      = rs1;
    id_ex_d.rs2      = rs2;
    id_ex_d.rd       = rd;
    id_ex_d.rs1_data = rs1_data;
    id_ex_d.rs2_data = rs2_data;
    case (opcode)
      OPC_OP: begin
        id_ex_d.use_imm = 1'b0;
        // funct7 is all zero, or 0100000 for sub and sra only
        id_ex_d.reg_write = (funct7 == 7'b0000000) ||
                            (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
        case (funct3)
          3'b000:  id_ex_d.alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
          3'b001:  id_ex_d.alu_op = ALU_SLL;
          3'b010:  id_ex_d.alu_op = ALU_SLT;
          3'b011:  id_ex_d.alu_op = ALU_SLTU;
          3'b100:  id_ex_d.alu_op = ALU_XOR;
          3'b101:  id_ex_d.alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
          3'b110:  id_ex_d.alu_op = ALU_OR;
          default: id_ex_d.alu_op = ALU_AND;
        endcase
      end
      OPC_OP_IMM: begin
        id_ex_d.use_imm   = 1'b1;
        id_ex_d.imm       = imm_i;
        id_ex_d.reg_write = 1'b1;
        case (funct3)
          3'b000:  id_ex_d.alu_op = ALU_ADD;
          3'b010:  id_ex_d.alu_op = ALU_SLT;
          3'b011:  id_ex_d.alu_op = ALU_SLTU;
          3'b100:  id_ex_d.alu_op = ALU_XOR;
          3'b110:  id_ex_d.alu_op = ALU_OR;
          3'b111:  id_ex_d.alu_op = ALU_AND;
          3'b001: begin
            id_ex_d.alu_op    = ALU_SLL;
            id_ex_d.imm       = imm_shamt;
            id_ex_d.reg_write = (funct7 == 7'b0000000);
          end
          default: begin
            // srli / srai
            id_ex_d.alu_op    = funct7[5] ? ALU_SRA : ALU_SRL;
            id_ex_d.imm       = imm_shamt;
            id_ex_d.reg_write = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
          end
        endcase
      end
      OPC_LUI: begin
        id_ex_d.alu_op    = ALU_PASS_B;
        id_ex_d.use_imm   = 1'b1;
        id_ex_d.imm       = imm_u;
        id_ex_d.reg_write = 1'b1;
      end
      default: begin
        // unknown opcode, keeps the no-write record
        id_ex_d.reg_write = 1'b0;
      end
    endcase
  end

  // ====================
  // id/ex register
  // ====================

  always_ff @(posedge clk) begin
    if (rst_i) begin
      id_ex_q <= ID_EX_NOP;
    end else begin
      id_ex_q <= id_ex_d;
    end
  end

  assign id_ex_o = id_ex_q;

endmodule

// File: design/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
  input  rv_pkg::id_ex_t  id_ex_i,
  input  rv_pkg::wb_req_t mem_fwd_i,
  input  rv_pkg::wb_req_t wb_fwd_i,
  output rv_pkg::wb_req_t ex_o
);

  import rv_pkg::*;

  xlen_t   op_a;
  xlen_t   rs2_val;
  xlen_t   op_b;
  xlen_t   alu_result;
  wb_req_t ex_d;

  // true when the record writes a nonzero rd matching src
  function automatic logic fwd_hit(
    input wb_req_t   req,
    input reg_addr_t src
  );
    return req.reg_write && (req.rd != '0) && (req.rd == src);
  endfunction

  // ====================
  // forwarding
  // ====================

  // mem result is younger, so it wins over wb
  function automatic xlen_t fwd_value(
    input reg_addr_t src,
    input xlen_t     rf_val,
    input wb_req_t   mem_req,
    input wb_req_t   wb_req
  );
    if (fwd_hit(mem_req, src)) begin
      return mem_req.data;
    end else if (fwd_hit(wb_req, src)) begin
      return wb_req.data;
    end
    return rf_val;
  endfunction

  assign op_a    = fwd_value(id_ex_i.rs1, id_ex_i.rs1_data, mem_fwd_i, wb_fwd_i);
  assign rs2_val = fwd_value(id_ex_i.rs2, id_ex_i.rs2_data, mem_fwd_i, wb_fwd_i);

  // ====================
  // operand b and alu
  // ====================

  // immediate forms ignore rs2 entirely
  assign op_b = id_ex_i.use_imm ? id_ex_i.imm : rs2_val;

  alu alu_inst (
    .op_i     (id_ex_i.alu_op),
    .a_i      (op_a),
    .b_i      (op_b),
    .result_o (alu_result)
  );

  // ====================
  // result record
  // ====================

  always_comb begin
    ex_d.rd        = id_ex_i.rd;
    ex_d.data      = alu_result;
    ex_d.reg_write = id_ex_i.reg_write;
  end

  assign ex_o = ex_d;

endmodule

// File: design/rv_core.sv
`timescale 1ns/1ps

module rv_core (
  input  logic              clk,
  input  logic              rst_i,
  input  logic              inst_valid_i,
  input  rv_pkg::inst_t     inst_i,
  output logic              wb_valid_o,
  output rv_pkg::reg_addr_t wb_rd_o,
  output rv_pkg::xlen_t     wb_data_o
);

  import rv_pkg::*;

  id_ex_t  id_ex;
  wb_req_t ex_req;
  wb_req_t ex_mem_q;
  wb_req_t mem_wb_q;

  // ====================
  // decode
  // ====================

  // register file sits in here, written from mem/wb
  decode_stage decode_inst (
    .clk          (clk),
    .rst_i        (rst_i),
    .inst_valid_i (inst_valid_i),
    .inst_i       (inst_i),
    .wb_i         (mem_wb_q),
    .id_ex_o      (id_ex)
  );

  // ====================
  // execute
  // ====================

  execute_stage execute_inst (
    .id_ex_i   (id_ex),
    .mem_fwd_i (ex_mem_q),
    .wb_fwd_i  (mem_wb_q),
    .ex_o      (ex_req)
  );

  // ====================
  // ex/mem register
  // ====================

  always_ff @(posedge clk) begin
    if (rst_i) begin
      ex_mem_q <= WB_NOP;
    end else begin
      ex_mem_q <= ex_req;
    end
  end

  // ====================
  // mem/wb register
  // ====================

  // no memory access in mem, the stage only feeds forwarding
  always_ff @(posedge clk) begin
    if (rst_i) begin
      mem_wb_q <= WB_NOP;
    end else begin
      mem_wb_q <= ex_mem_q;
    end
  end

  // ====================
  // write-back port
  // ====================

  // writes to x0 are dropped from the port
  assign wb_valid_o = mem_wb_q.reg_write && (mem_wb_q.rd != '0);
  assign wb_rd_o    = mem_wb_q.rd;
  assign wb_data_o  = mem_wb_q.data;

endmodule

// File: testbench/rv_core_checker.sv
`timescale 1ns/1ps

module rv_core_checker (
  input logic              clk,
  input logic              rst_i,
  input logic              inst_valid_i,
  input rv_pkg::inst_t     inst_i,
  input logic              wb_valid_i,
  input rv_pkg::reg_addr_t wb_rd_i,
  input rv_pkg::xlen_t     wb_data_i
);

  import rv_pkg::*;

  localparam int unsigned WB_LATENCY = 4;

  // expected write-backs in program order
  reg_addr_t   exp_rd       [$];
  xlen_t       exp_data     [$];
  // writing instructions not yet seen on the instruction port
  inst_t       await_accept [$];
  int unsigned accept_cycle [$];
  int unsigned cycle        = 0;
  int unsigned checks       = 0;
  int unsigned mismatches   = 0;
  int unsigned other_errors = 0;

  function automatic void push_expected(input inst_t w, input reg_addr_t rd, input xlen_t data);
    exp_rd.push_back(rd);
    exp_data.push_back(data);
    await_accept.push_back(w);
  endfunction

  function automatic int pending_count();
    return exp_rd.size();
  endfunction

  function automatic int unsigned error_count();
    return mismatches + other_errors;
  endfunction

  task automatic print_summary(input int unsigned assert_failures);
    $display("checks=%0d mismatches=%0d other_errors=%0d assert_failures=%0d pending=%0d",
             checks, mismatches, other_errors, assert_failures, exp_rd.size());
  endtask

  // ====================
  // write-back compare
  // ====================

  task automatic check_writeback();
    int unsigned latency;
    if (exp_rd.size() == 0) begin
      $display("ERROR time=%0t: write-back to x%0d data %h arrived with nothing expected",
               $time, wb_rd_i, wb_data_i);
      other_errors++;
      return;
    end
    checks++;
    if (wb_rd_i !== exp_rd[0]) begin
      $display("MISMATCH time=%0t signal=wb_rd_o expected=%0d actual=%0d",
               $time, exp_rd[0], wb_rd_i);
      mismatches++;
    end
    if (wb_data_i !== exp_data[0]) begin
      $display("MISMATCH time=%0t signal=wb_data_o expected=%h actual=%h",
               $time, exp_data[0], wb_data_i);
      mismatches++;
    end
    void'(exp_rd.pop_front());
    void'(exp_data.pop_front());
    if (accept_cycle.size() == 0) begin
      $display("ERROR time=%0t: write-back seen before its instruction was accepted", $time);
      other_errors++;
    end else begin
      latency = cycle - accept_cycle.pop_front();
      if (latency != WB_LATENCY) begin
        $display("MISMATCH time=%0t signal=latency expected=%0d actual=%0d",
                 $time, WB_LATENCY, latency);
        mismatches++;
      end
    end
  endtask

  always @(posedge clk) begin
    if (!rst_i) begin
      // note the edge that takes the next writing instruction
      if (inst_valid_i && await_accept.size() > 0 && inst_i == await_accept[0]) begin
        void'(await_accept.pop_front());
        accept_cycle.push_back(cycle);
      end
      if (wb_valid_i) begin
        check_writeback();
      end
    end
    cycle = cycle + 1;
  end

endmodule

// File: testbench/rv_core_assert.sv
`timescale 1ns/1ps

module rv_core_assert (
  input logic              clk,
  input logic              rst_i,
  input logic              wb_valid_i,
  input rv_pkg::reg_addr_t wb_rd_i,
  input rv_pkg::xlen_t     wb_data_i
);

  int unsigned failures = 0;

  // pipeline registers come out of reset as empty records
  valid_low_in_reset: assert property (@(posedge clk) rst_i |=> !wb_valid_i)
    else begin
      failures++;
      $error("wb_valid_o high in the cycle after a reset edge");
    end

  // writes to x0 never reach the port
  rd_nonzero: assert property (@(posedge clk) disable iff (rst_i)
    wb_valid_i |-> (wb_rd_i != '0))
    else begin
      failures++;
      $error("wb_valid_o high with wb_rd_o equal to zero");
    end

  data_known: assert property (@(posedge clk) disable iff (rst_i)
    wb_valid_i |-> !$isunknown(wb_data_i))
    else begin
      failures++;
      $error("wb_data_o has unknown bits while wb_valid_o is high");
    end

endmodule

bind rv_core rv_core_assert rv_core_assert_inst (
  .clk        (clk),
  .rst_i      (rst_i),
  .wb_valid_i (wb_valid_o),
  .wb_rd_i    (wb_rd_o),
  .wb_data_i  (wb_data_o)
);

// File: testbench/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;

  import rv_pkg::*;

  localparam int          RANDOM_ENTRIES = 14;
  localparam int          DRAIN_TIMEOUT  = 100;
  localparam logic [15:0] LFSR_SEED      = 16'd44;

  logic      clk;
  logic      rst_i;
  logic      inst_valid_i;
  inst_t     inst_i;
  logic      wb_valid_o;
  reg_addr_t wb_rd_o;
  xlen_t     wb_data_o;

  // one instruction word and its leading bubble count per entry
  inst_t       stim_inst [$];
  int          stim_gap  [$];
  xlen_t       ref_regs  [32];
  logic [15:0] lfsr;
  int          wait_cycles;
  logic        timed_out;

  rv_core rv_core_inst (
    .clk          (clk),
    .rst_i        (rst_i),
    .inst_valid_i (inst_valid_i),
    .inst_i       (inst_i),
    .wb_valid_o   (wb_valid_o),
    .wb_rd_o      (wb_rd_o),
    .wb_data_o    (wb_data_o)
  );

  rv_core_checker rv_core_checker_inst (
    .clk          (clk),
    .rst_i        (rst_i),
    .inst_valid_i (inst_valid_i),
    .inst_i       (inst_i),
    .wb_valid_i   (wb_valid_o),
    .wb_rd_i      (wb_rd_o),
    .wb_data_i    (wb_data_o)
  );

  always #4 clk = ~clk;

  // fibonacci lfsr, taps 16 14 13 11, one step per bit
  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int k = 0; k < n; k++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      val  = {val[30:0], fb};
    end
    return val;
  endfunction

  // ====================
  // instruction encoding
  // ====================

  function automatic inst_t rtype_word(input int f7, input int f3, input int rd,
                                       input int rs1, input int rs2);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OPC_OP};
  endfunction

  function automatic inst_t itype_word(input int f3, input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], OPC_OP_IMM};
  endfunction

  function automatic inst_t lui_word(input int rd, input int imm);
    return {imm[19:0], rd[4:0], OPC_LUI};
  endfunction

  task automatic add_entry(input inst_t w, input int gap);
    stim_inst.push_back(w);
    stim_gap.push_back(gap);
  endtask

  // sequential ISA semantics over ref_regs, returns 1 when rd is written
  function automatic logic reference_step(input inst_t w, output reg_addr_t rd, output xlen_t val);
    logic [6:0] opc;
    logic [2:0] f3;
    xlen_t      a;
    xlen_t      b;
    logic [4:0] sh;
    opc = w[6:0];
    rd  = w[11:7];
    f3  = w[14:12];
    a   = ref_regs[w[19:15]];
    b   = (opc == OPC_OP) ? ref_regs[w[24:20]] : {{20{w[31]}}, w[31:20]};
    sh  = b[4:0];
    val = '0;
    if (opc == OPC_LUI) begin
      val = {w[31:12], 12'h000};
      return 1'b1;
    end
    if (opc != OPC_OP && opc != OPC_OP_IMM) begin
      return 1'b0;
    end
    case (f3)
      3'd0: val = (opc == OPC_OP && w[30]) ? a - b : a + b;
      3'd1: val = a << sh;
      3'd2: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: val = (a < b) ? 32'd1 : 32'd0;
      3'd4: val = a ^ b;
      3'd5: val = w[30] ? $unsigned($signed(a) >>> sh) : a >> sh;
      3'd6: val = a | b;
      default: val = a & b;
    endcase
    return 1'b1;
  endfunction

  // ====================
  // stimulus table
  // ====================

  task automatic build_table();
    int rd;
    int f3;
    int f7;
    int imm;
    // long bubble run first, port must stay quiet
    add_entry(lui_word(1, 'h80000), 8);
    add_entry(itype_word(0, 2, 0, -1), 0);
    add_entry(itype_word(0, 3, 0, 5), 1);
    add_entry(lui_word(4, random_bits(20)), 0);
    add_entry(itype_word(0, 4, 4, random_bits(12)), 0);
    // register-register group with edge operands
    add_entry(rtype_word(0, 0, 5, 1, 2), 0);
    add_entry(rtype_word('h20, 0, 6, 3, 2), 0);
    add_entry(rtype_word(0, 1, 7, 2, 3), 0);
    add_entry(rtype_word(0, 2, 8, 1, 3), 0);
    add_entry(rtype_word(0, 3, 9, 1, 3), 0);
    add_entry(rtype_word(0, 4, 10, 4, 2), 0);
    add_entry(rtype_word(0, 5, 11, 1, 3), 0);
    add_entry(rtype_word('h20, 5, 12, 1, 3), 0);
    add_entry(rtype_word(0, 6, 13, 1, 3), 0);
    add_entry(rtype_word(0, 7, 14, 4, 2), 0);
    add_entry(rtype_word(0, 1, 23, 3, 2), 0);
    // register-immediate group
    add_entry(itype_word(2, 15, 2, 0), 0);
    add_entry(itype_word(3, 16, 3, -1), 0);
    add_entry(itype_word(4, 17, 4, 'h800), 0);
    add_entry(itype_word(6, 18, 3, 'h7f0), 0);
    add_entry(itype_word(7, 19, 2, 'h0f0), 0);
    add_entry(itype_word(1, 20, 3, 31), 0);
    add_entry(itype_word(5, 21, 1, 4), 0);
    add_entry(itype_word(5, 22, 1, 'h404), 0);
    // dependent chain at distances 1 to 4
    add_entry(itype_word(0, 26, 0, 100), 2);
    add_entry(itype_word(0, 26, 26, 3), 0);
    add_entry(rtype_word('h20, 0, 27, 26, 3), 1);
    add_entry(rtype_word(0, 4, 28, 27, 26), 2);
    add_entry(rtype_word(0, 6, 29, 28, 27), 3);
    // x0 writes and unknown opcodes write nothing
    add_entry(itype_word(0, 0, 2, 77), 0);
    add_entry(rtype_word(0, 0, 9, 0, 3), 0);
    add_entry(32'h0020_a223, 0);
    add_entry(32'h0000_0f80, 0);
    add_entry(rtype_word(0, 0, 30, 31, 0), 0);
    for (int k = 0; k < RANDOM_ENTRIES; k++) begin
      rd = random_bits(5) % 31 + 1;
      f3 = random_bits(3);
      if (random_bits(1) == 1) begin
        f7 = ((f3 == 0 || f3 == 5) && random_bits(1) == 1) ? 'h20 : 0;
        add_entry(rtype_word(f7, f3, rd, random_bits(5), random_bits(5)), random_bits(2));
      end else begin
        imm = random_bits(12);
        if (f3 == 1) begin
          imm = imm & 'h1f;
        end else if (f3 == 5) begin
          imm = imm & 'h41f;
        end
        add_entry(itype_word(f3, rd, random_bits(5), imm), random_bits(2));
      end
    end
  endtask

  task automatic compute_expected();
    reg_addr_t rd;
    xlen_t     val;
    logic      writes;
    for (int r = 0; r < 32; r++) begin
      ref_regs[r] = '0;
    end
    foreach (stim_inst[i]) begin
      writes = reference_step(stim_inst[i], rd, val);
      if (writes && rd != '0) begin
        ref_regs[rd] = val;
        rv_core_checker_inst.push_expected(stim_inst[i], rd, val);
      end
    end
  endtask

  initial begin
    clk          = 1'b0;
    rst_i        = 1'b1;
    inst_valid_i = 1'b0;
    inst_i       = NOP_INST;
    lfsr         = LFSR_SEED;
    timed_out    = 1'b0;
    build_table();
    compute_expected();
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_i = 1'b0;

    foreach (stim_inst[i]) begin
      for (int g = 0; g < stim_gap[i]; g++) begin
        @(negedge clk);
        inst_valid_i = 1'b0;
        inst_i       = NOP_INST;
      end
      @(negedge clk);
      inst_valid_i = 1'b1;
      inst_i       = stim_inst[i];
    end
    @(negedge clk);
    inst_valid_i = 1'b0;
    inst_i       = NOP_INST;

    // drain the pipeline
    wait_cycles = 0;
    while (rv_core_checker_inst.pending_count() != 0 && wait_cycles < DRAIN_TIMEOUT) begin
      @(posedge clk);
      wait_cycles++;
    end
    if (rv_core_checker_inst.pending_count() != 0) begin
      $display("ERROR: timed out waiting for %0d expected write-backs",
               rv_core_checker_inst.pending_count());
      timed_out = 1'b1;
    end
    // room for a stray write-back to show up
    repeat (6) @(posedge clk);

    rv_core_checker_inst.print_summary(rv_core_inst.rv_core_assert_inst.failures);
    if (rv_core_checker_inst.error_count() == 0 && !timed_out &&
        rv_core_inst.rv_core_assert_inst.failures == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: verilog.f
design/rv_pkg.sv
design/alu.sv
design/reg_file.sv
design/decode_stage.sv
design/execute_stage.sv
design/rv_core.sv
testbench/rv_core_checker.sv
testbench/rv_core_assert.sv
testbench/tb_rv_core.sv

// File: Makefile
TOP := tb_rv_core

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f verilog.f

obj_dir/V$(TOP): verilog.f design/*.sv testbench/*.sv
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f

# exit status comes from the search for the pass line
sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -Fx '=== PASS ===' > /dev/null

clean:
	rm -rf obj_dir
